// ==== list.f ====
+incdir+rtl
rtl/eis_pkg.sv
rtl/eis_divider.sv
rtl/eis_multiplier.sv
rtl/eis_shifter.sv
rtl/eis_cond_codes.sv
rtl/eis_unit.sv
tb/eis_unit_tb.sv

// ==== rtl/eis_cond_codes.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_cond_codes
(
   input  eis_pkg::eis_req_t      req,
   input  logic [`EIS_WORD_W-1:0] quotient,
   input  logic [`EIS_WORD_W-1:0] remainder,
   input  logic                   div_overflow,
   input  logic [`EIS_LONG_W-1:0] product,
   input  eis_pkg::eis_pair_t     shifted,
   input  logic                   carry,
   input  logic                   sign_change,
   output eis_pkg::eis_result_t   result
);

   import eis_pkg::*;

   logic div_by_zero;
   logic mul_wide;

   assign div_by_zero = (req.src == '0);

   // product needs more than 16 signed bits
   assign mul_wide = product[`EIS_LONG_W-1:`EIS_WORD_W-1] !=
                     {(`EIS_WORD_W + 1){product[`EIS_WORD_W-1]}};

   always_comb
   begin
      result.pair = req.pair;
      result.cc = '0;
      case (req.op)
         op_div:
         begin
            result.cc.n = quotient[`EIS_WORD_W-1];
            result.cc.z = (quotient == '0);
            result.cc.v = div_overflow | div_by_zero;
            result.cc.c = div_by_zero;
            // on overflow the registers keep the dividend
            if (!result.cc.v)
            begin
               result.pair.words.hi = quotient;
               result.pair.words.lo = remainder;
            end
         end
         op_mul:
         begin
            result.pair.full = product;
            result.cc.n = product[`EIS_LONG_W-1];
            result.cc.z = (product == '0);
            result.cc.c = mul_wide;
         end
         op_ash:
         begin
            result.pair = shifted;
            result.cc.n = shifted.words.lo[`EIS_WORD_W-1];
            result.cc.z = (shifted.words.lo == '0);
            result.cc.v = sign_change;
            result.cc.c = carry;
         end
         default:
         begin
            result.pair = shifted;
            result.cc.n = shifted.full[`EIS_LONG_W-1];
            result.cc.z = (shifted.full == '0);
            result.cc.v = sign_change;
            result.cc.c = carry;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/eis_consts.svh ====
`ifndef EIS_CONSTS_SVH
`define EIS_CONSTS_SVH

// PDP-11 word and register-pair widths
`define EIS_WORD_W 16
`define EIS_LONG_W 32

// one quotient bit per divider step
`define EIS_DIV_STEPS 32

// operation codes, in the order of the EIS opcodes 070..073
`define EIS_OP_MUL 2'd0
`define EIS_OP_DIV 2'd1
`define EIS_OP_ASH 2'd2
`define EIS_OP_ASHC 2'd3

`endif

// ==== rtl/eis_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_divider
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   ready,
   input  logic [`EIS_LONG_W-1:0] dividend,
   input  logic [`EIS_WORD_W-1:0] divisor,
   output logic [`EIS_WORD_W-1:0] quotient,
   output logic [`EIS_WORD_W-1:0] remainder,
   output logic                   overflow,
   output logic                   done
);

   localparam int acc_w = 2 * `EIS_LONG_W;
   localparam int cnt_w = $clog2(`EIS_DIV_STEPS + 1);

   // quotient magnitude limits for a 16-bit signed result
   localparam logic [`EIS_LONG_W-1:0] pos_limit = 32'h0000_7fff;
   localparam logic [`EIS_LONG_W-1:0] neg_limit = 32'h0000_8000;

   typedef enum logic [1:0]
   {
      st_idle,
      st_running,
      st_last
   } state_t;

   state_t                 state;
   state_t                 next_state;
   logic [cnt_w-1:0]       bitnum;
   logic [`EIS_LONG_W-1:0] quotient_temp;
   logic [acc_w-1:0]       dividend_copy;
   logic [acc_w-1:0]       divisor_copy;
   logic [acc_w-1:0]       diff;
   logic                   negative_output;
   logic                   dividend_neg;
   logic [`EIS_LONG_W-1:0] dividend_mag;
   logic [`EIS_WORD_W-1:0] divisor_mag;

   assign dividend_mag = dividend[`EIS_LONG_W-1] ? -dividend : dividend;
   assign divisor_mag = divisor[`EIS_WORD_W-1] ? -divisor : divisor;

   // trial subtraction, a borrow shows up in the top bit
   assign diff = dividend_copy - divisor_copy;

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
            if (ready)
               next_state = st_running;
         st_running:
            if (bitnum == cnt_w'(1))
               next_state = st_last;
         st_last:
            // hold here until the requester lets go of ready
            if (!ready)
               next_state = st_idle;
         default:
            next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         done <= 1'b0;
      end
      else
      begin
         state <= next_state;
         // single pulse on the first cycle of last
         done <= (state == st_last) && ready && !done;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         bitnum <= '0;
      else if (state == st_idle)
         bitnum <= cnt_w'(`EIS_DIV_STEPS);
      else if (state == st_running)
         bitnum <= bitnum - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      case (state)
         st_idle:
         begin
            quotient_temp <= '0;
            dividend_copy <= {{`EIS_LONG_W{1'b0}}, dividend_mag};
            // divisor starts aligned with quotient bit 31
            divisor_copy <= {{(`EIS_WORD_W + 1){1'b0}}, divisor_mag,
                             {(`EIS_LONG_W - 1){1'b0}}};
            negative_output <= dividend[`EIS_LONG_W-1] ^ divisor[`EIS_WORD_W-1];
            dividend_neg <= dividend[`EIS_LONG_W-1];
         end
         st_running:
         begin
            quotient_temp <= {quotient_temp[`EIS_LONG_W-2:0], ~diff[acc_w-1]};
            if (!diff[acc_w-1])
               dividend_copy <= diff;
            divisor_copy <= divisor_copy >> 1;
         end
         default:
         begin
            // apply the signs; the remainder follows the dividend
            quotient <= negative_output ? -quotient_temp[`EIS_WORD_W-1:0]
                                        : quotient_temp[`EIS_WORD_W-1:0];
            remainder <= dividend_neg ? -dividend_copy[`EIS_WORD_W-1:0]
                                      : dividend_copy[`EIS_WORD_W-1:0];
            // a zero divisor leaves all ones here, so it trips this too
            overflow <= quotient_temp > (negative_output ? neg_limit : pos_limit);
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/eis_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_multiplier
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  logic [`EIS_WORD_W-1:0] multiplicand,
   input  logic [`EIS_WORD_W-1:0] multiplier,
   output logic [`EIS_LONG_W-1:0] product,
   output logic                   done
);

   localparam int cnt_w = $clog2(`EIS_WORD_W + 1);

   logic                   running;
   logic [cnt_w-1:0]       steps_left;
   logic [`EIS_LONG_W-1:0] acc;
   logic [`EIS_LONG_W-1:0] addend;
   logic [`EIS_WORD_W-1:0] mplier_bits;
   logic                   negate;
   logic [`EIS_WORD_W-1:0] mcand_mag;
   logic [`EIS_WORD_W-1:0] mplier_mag;

   assign mcand_mag = multiplicand[`EIS_WORD_W-1] ? -multiplicand : multiplicand;
   assign mplier_mag = multiplier[`EIS_WORD_W-1] ? -multiplier : multiplier;

   // magnitude product is at most 2**30, so the sign fits back in
   assign product = negate ? -acc : acc;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         running <= 1'b0;
         steps_left <= '0;
         done <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         if (start && !running)
         begin
            running <= 1'b1;
            steps_left <= cnt_w'(`EIS_WORD_W);
         end
         else if (running)
         begin
            steps_left <= steps_left - 1'b1;
            if (steps_left == cnt_w'(1))
            begin
               running <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start && !running)
      begin
         acc <= '0;
         addend <= {{`EIS_WORD_W{1'b0}}, mcand_mag};
         mplier_bits <= mplier_mag;
         negate <= multiplicand[`EIS_WORD_W-1] ^ multiplier[`EIS_WORD_W-1];
      end
      else if (running)
      begin
         // one multiplier bit per cycle, lsb first
         if (mplier_bits[0])
            acc <= acc + addend;
         addend <= addend << 1;
         mplier_bits <= mplier_bits >> 1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/eis_pkg.sv ====
`default_nettype none

`include "eis_consts.svh"

package eis_pkg;

   typedef enum logic [1:0]
   {
      op_mul  = `EIS_OP_MUL,
      op_div  = `EIS_OP_DIV,
      op_ash  = `EIS_OP_ASH,
      op_ashc = `EIS_OP_ASHC
   } eis_op_t;

   // hi is the even register R, lo is R+1
   typedef struct packed
   {
      logic [`EIS_WORD_W-1:0] hi;
      logic [`EIS_WORD_W-1:0] lo;
   } eis_words_t;

   // the register pair, seen as one long or as two words
   typedef union packed
   {
      logic signed [`EIS_LONG_W-1:0] full;
      eis_words_t                    words;
   } eis_pair_t;

   // src is the divisor, the multiplier or the shift count
   typedef struct packed
   {
      eis_op_t                op;
      logic [`EIS_WORD_W-1:0] src;
      eis_pair_t              pair;
   } eis_req_t;

   typedef struct packed
   {
      logic n;
      logic z;
      logic v;
      logic c;
   } eis_cc_t;

   typedef struct packed
   {
      eis_pair_t pair;
      eis_cc_t   cc;
   } eis_result_t;

endpackage

`default_nettype wire

// ==== rtl/eis_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_shifter
(
   input  eis_pkg::eis_op_t   op,
   input  logic [5:0]         count,
   input  eis_pkg::eis_pair_t operand,
   output eis_pkg::eis_pair_t shifted,
   output logic               carry,
   output logic               sign_change
);

   import eis_pkg::*;

   localparam int msb = `EIS_LONG_W - 1;

   logic                   left;
   logic [5:0]             amount;
   logic                   is_ashc;
   logic [`EIS_LONG_W-1:0] val;

   // count is a signed 6-bit field, -32 gives an amount of 32
   assign left = !count[5];
   assign amount = left ? count : -count;
   assign is_ashc = (op == op_ashc);

   always_comb
   begin
      // ASH works on R+1 parked in the upper half, so bit 31 is its sign
      val = is_ashc ? operand.full : {operand.words.lo, {`EIS_WORD_W{1'b0}}};
      carry = 1'b0;
      sign_change = 1'b0;
      for (int i = 0; i < `EIS_LONG_W; i++)
      begin
         if (i < amount)
         begin
            if (left)
            begin
               carry = val[msb];
               val = val << 1;
               sign_change = sign_change | (val[msb] ^ carry);
            end
            else
            begin
               // the word's own lsb drops out, not the padding
               carry = is_ashc ? val[0] : val[`EIS_WORD_W];
               val = {val[msb], val[msb:1]};
            end
         end
      end
   end

   always_comb
   begin
      shifted = operand;
      if (is_ashc)
         shifted.full = val;
      else
         shifted.words.lo = val[msb:`EIS_WORD_W];
   end

endmodule

`default_nettype wire

// ==== rtl/eis_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_unit
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  eis_pkg::eis_req_t    req,
   output logic                 busy,
   output logic                 done,
   output eis_pkg::eis_result_t result
);

   import eis_pkg::*;

   eis_req_t               req_q;
   logic                   div_ready;
   logic                   div_done;
   logic                   div_overflow;
   logic [`EIS_WORD_W-1:0] quotient;
   logic [`EIS_WORD_W-1:0] remainder;
   logic                   mul_start;
   logic                   mul_done;
   logic [`EIS_LONG_W-1:0] product;
   eis_pair_t              shifted;
   logic                   carry;
   logic                   sign_change;
   eis_result_t            result_d;
   logic                   finish;

   eis_divider eis_divider_inst
   (
      .clk       (clk),
      .reset     (reset),
      .ready     (div_ready),
      .dividend  (req_q.pair.full),
      .divisor   (req_q.src),
      .quotient  (quotient),
      .remainder (remainder),
      .overflow  (div_overflow),
      .done      (div_done)
   );

   // MUL multiplies the single register R+1 by the source
   eis_multiplier eis_multiplier_inst
   (
      .clk          (clk),
      .reset        (reset),
      .start        (mul_start),
      .multiplicand (req_q.pair.words.lo),
      .multiplier   (req_q.src),
      .product      (product),
      .done         (mul_done)
   );

   eis_shifter eis_shifter_inst
   (
      .op          (req_q.op),
      .count       (req_q.src[5:0]),
      .operand     (req_q.pair),
      .shifted     (shifted),
      .carry       (carry),
      .sign_change (sign_change)
   );

   eis_cond_codes eis_cond_codes_inst
   (
      .req          (req_q),
      .quotient     (quotient),
      .remainder    (remainder),
      .div_overflow (div_overflow),
      .product      (product),
      .shifted      (shifted),
      .carry        (carry),
      .sign_change  (sign_change),
      .result       (result_d)
   );

   // shifts finish on the first busy cycle
   always_comb
   begin
      case (req_q.op)
         op_div:
            finish = div_done;
         op_mul:
            finish = mul_done;
         default:
            finish = 1'b1;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         done <= 1'b0;
         div_ready <= 1'b0;
         mul_start <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         mul_start <= 1'b0;
         if (!busy)
         begin
            if (start)
            begin
               busy <= 1'b1;
               div_ready <= (req.op == op_div);
               mul_start <= (req.op == op_mul);
            end
         end
         else if (finish)
         begin
            busy <= 1'b0;
            done <= 1'b1;
            div_ready <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start && !busy)
         req_q <= req;
      if (busy && finish)
         result <= result_d;
   end

endmodule

`default_nettype wire

// ==== tb/eis_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eis_consts.svh"

module eis_unit_tb;

   import eis_pkg::*;

   localparam int half_period = 10;
   localparam int wait_limit = 100;
   localparam int div_latency = 36;
   localparam int mul_latency = 19;
   localparam int shift_latency = 2;

   logic        clk;
   logic        reset;
   logic        start;
   eis_req_t    req;
   logic        busy;
   logic        done;
   eis_result_t result;

   logic [15:0] lfsr_state;
   int          error_count;
   int          tests_run;
   int          tests_failed;
   int          errors_at_open;

   // fixed counts around the word and long boundaries
   int edge_counts [11] = '{0, 1, 15, 16, 17, 31, -1, -15, -16, -17, -32};

   eis_unit eis_unit_inst
   (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .req    (req),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   always #(half_period) clk = ~clk;

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      assert (got === expected)
      else
      begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
         error_count++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("%s", what);
         error_count++;
      end
   endtask

   task automatic open_test;
      errors_at_open = error_count;
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (error_count == errors_at_open)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d checks wrong", name, error_count - errors_at_open);
      end
   endtask

   task automatic send_request(input eis_req_t r);
      @(posedge clk);
      start <= 1'b1;
      req <= r;
      @(posedge clk);
      start <= 1'b0;
   endtask

   // first is the number of edges already passed since the request went in
   task automatic wait_done(input int first, output int cycles, output logic got);
      cycles = first;
      got = 1'b0;
      while (!got && cycles <= wait_limit)
      begin
         @(negedge clk);
         if (done)
         begin
            got = 1'b1;
            expect_true(!busy, "busy still high in the done cycle");
         end
         else
         begin
            expect_true(busy, "busy low while a request is in progress");
            @(posedge clk);
            cycles++;
         end
      end
      if (!got)
      begin
         $display("no done pulse within %0d cycles of the request", wait_limit);
         error_count++;
      end
   endtask

   task automatic issue_and_wait(input eis_req_t r, input int latency,
                                 output eis_result_t res);
      int   cycles;
      logic got;
      send_request(r);
      wait_done(1, cycles, got);
      expect_equal("latency", cycles, latency);
      res = result;
   endtask

   task automatic divide_case(input logic [31:0] dividend, input logic [15:0] divisor);
      eis_req_t    r;
      eis_result_t res;
      longint      q;
      longint      rem;
      logic        v;
      logic        c;
      r.op = op_div;
      r.src = divisor;
      r.pair.full = dividend;
      c = (divisor == 16'h0000);
      q = 0;
      rem = 0;
      if (c)
         v = 1'b1;
      else
      begin
         // truncating division, remainder keeps the dividend's sign
         q = longint'(signed'(dividend)) / longint'(signed'(divisor));
         rem = longint'(signed'(dividend)) % longint'(signed'(divisor));
         v = (q > 32767) || (q < -32768);
      end
      issue_and_wait(r, div_latency, res);
      expect_equal("cc.v", res.cc.v, v);
      expect_equal("cc.c", res.cc.c, c);
      if (v)
         expect_equal("result.pair", res.pair, dividend);
      else
      begin
         expect_equal("result.pair.hi", res.pair.words.hi, q[15:0]);
         expect_equal("result.pair.lo", res.pair.words.lo, rem[15:0]);
         expect_equal("cc.n", res.cc.n, q < 0);
         expect_equal("cc.z", res.cc.z, q == 0);
      end
   endtask

   task automatic multiply_case(input logic [15:0] lo, input logic [15:0] src,
                                input logic [15:0] hi);
      eis_req_t    r;
      eis_result_t res;
      longint      p;
      r.op = op_mul;
      r.src = src;
      r.pair.words.hi = hi;
      r.pair.words.lo = lo;
      p = longint'(signed'(lo)) * longint'(signed'(src));
      issue_and_wait(r, mul_latency, res);
      expect_equal("result.pair", res.pair, p[31:0]);
      expect_equal("cc.n", res.cc.n, p < 0);
      expect_equal("cc.z", res.cc.z, p == 0);
      expect_equal("cc.v", res.cc.v, 1'b0);
      expect_equal("cc.c", res.cc.c, (p > 32767) || (p < -32768));
   endtask

   // sign at step k of a left shift is bit width-1-k, or a shifted-in zero
   task automatic shift_model(input logic [31:0] val, input int width, input int count,
                              output logic [31:0] res, output logic carry, output logic v);
      logic [63:0] mask;
      longint      sval;
      int          n;
      logic        sign0;
      mask = (64'd1 << width) - 64'd1;
      sign0 = val[width-1];
      carry = 1'b0;
      v = 1'b0;
      if (count >= 0)
      begin
         n = count;
         res = 32'((64'(val) << n) & mask);
         if (n >= 1 && n <= width)
            carry = val[width-n];
         for (int k = 1; k <= n; k++)
         begin
            if (k <= width - 1)
            begin
               if (val[width-1-k] != sign0)
                  v = 1'b1;
            end
            else if (sign0)
               v = 1'b1;
         end
      end
      else
      begin
         n = -count;
         sval = sign0 ? longint'(64'(val) | ~mask) : longint'(64'(val));
         res = 32'(64'(sval >>> n) & mask);
         carry = (n <= width) ? val[n-1] : sign0;
      end
   endtask

   task automatic shift_case(input eis_op_t op, input logic [15:0] src,
                             input eis_pair_t pair);
      eis_req_t    r;
      eis_result_t res;
      eis_pair_t   exp_pair;
      logic [31:0] val;
      logic [31:0] shifted;
      logic        carry;
      logic        v;
      int          count;
      int          width;
      r.op = op;
      r.src = src;
      r.pair = pair;
      count = int'(signed'(src[5:0]));
      width = (op == op_ashc) ? `EIS_LONG_W : `EIS_WORD_W;
      val = (op == op_ashc) ? pair.full : {16'h0000, pair.words.lo};
      shift_model(val, width, count, shifted, carry, v);
      exp_pair = pair;
      if (op == op_ashc)
         exp_pair.full = shifted;
      else
         exp_pair.words.lo = shifted[15:0];
      issue_and_wait(r, shift_latency, res);
      expect_equal("result.pair", res.pair, exp_pair);
      expect_equal("cc.n", res.cc.n, shifted[width-1]);
      expect_equal("cc.z", res.cc.z, shifted == 32'h0);
      expect_equal("cc.v", res.cc.v, v);
      expect_equal("cc.c", res.cc.c, carry);
   endtask

   // a MUL offered in the middle of a DIV must be dropped
   task automatic ignored_start_case;
      eis_req_t    r;
      eis_req_t    other;
      eis_result_t res;
      int          cycles;
      logic        got;
      int          extra;
      r.op = op_div;
      r.src = 16'h0007;
      r.pair.full = 32'h0001_2345;
      other.op = op_mul;
      other.src = 16'h1234;
      other.pair.full = 32'hdead_beef;
      send_request(r);
      @(posedge clk);
      start <= 1'b1;
      req <= other;
      @(posedge clk);
      start <= 1'b0;
      wait_done(3, cycles, got);
      res = result;
      expect_equal("latency", cycles, div_latency);
      expect_equal("result.pair", res.pair, {16'(74565 / 7), 16'(74565 % 7)});
      expect_equal("result.cc", res.cc, 4'b0000);
      extra = 0;
      for (int k = 0; k < 60; k++)
      begin
         @(negedge clk);
         if (done)
            extra++;
      end
      expect_equal("extra done pulses", extra, 0);
      expect_true(!busy, "unit went busy again from an ignored start");
   endtask

   initial
   begin
      longint      dmag;
      longint      qmag;
      longint      rmag;
      longint      mag;
      eis_pair_t   pair;
      clk = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      req = '0;
      lfsr_state = 16'd36155;
      error_count = 0;
      tests_run = 0;
      tests_failed = 0;
      errors_at_open = 0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      open_test;
      @(negedge clk);
      expect_equal("busy", busy, 1'b0);
      expect_equal("done", done, 1'b0);
      expect_equal("div_ready", eis_unit_inst.div_ready, 1'b0);
      expect_equal("mul_start", eis_unit_inst.mul_start, 1'b0);
      expect_equal("div_done", eis_unit_inst.div_done, 1'b0);
      expect_equal("mul_done", eis_unit_inst.mul_done, 1'b0);
      close_test("reset");

      // quotient and remainder are built first so the quotient stays in range
      open_test;
      for (int i = 0; i < 40; i++)
      begin
         dmag = random_bits(15);
         if (dmag == 0)
            dmag = 1;
         qmag = random_bits(15);
         rmag = random_bits(16) % dmag;
         mag = qmag * dmag + rmag;
         divide_case(i[1] ? 32'(-mag) : 32'(mag), i[0] ? 16'(-dmag) : 16'(dmag));
      end
      close_test("div random");

      open_test;
      divide_case(32'h0000_1234, 16'h0000);
      divide_case(32'hffff_0000, 16'h0000);
      divide_case(32'h0000_8000, 16'h0001);
      divide_case(32'hffff_8000, 16'h0001);
      divide_case(32'hffff_7fff, 16'h0001);
      divide_case(32'h0000_7fff, 16'h0001);
      divide_case(32'hffff_8000, 16'hffff);
      divide_case(32'h8000_0000, 16'hffff);
      divide_case(32'h7fff_ffff, 16'h7fff);
      divide_case(32'h3fff_8000, 16'h8000);
      // zero quotient with a remainder of either sign
      divide_case(32'h0000_0005, 16'h0007);
      divide_case(32'hffff_fffb, 16'h0007);
      close_test("div edge");

      open_test;
      for (int i = 0; i < 40; i++)
         multiply_case(16'(random_bits(16)), 16'(random_bits(16)), 16'(random_bits(16)));
      multiply_case(16'h8000, 16'h8000, 16'h0000);
      multiply_case(16'h7fff, 16'h7fff, 16'h0000);
      multiply_case(16'hffff, 16'hffff, 16'hffff);
      multiply_case(16'h0000, 16'h8000, 16'h5555);
      multiply_case(16'd181, 16'd181, 16'h0000);
      multiply_case(16'd182, 16'd181, 16'h0000);
      close_test("mul");

      open_test;
      for (int i = 0; i < 40; i++)
      begin
         pair.full = random_bits(32);
         shift_case(op_ash, 16'(random_bits(16)), pair);
      end
      for (int i = 0; i < 11; i++)
      begin
         pair.full = random_bits(32);
         shift_case(op_ash, 16'(edge_counts[i]), pair);
      end
      close_test("ash");

      open_test;
      for (int i = 0; i < 40; i++)
      begin
         pair.full = random_bits(32);
         shift_case(op_ashc, 16'(random_bits(16)), pair);
      end
      for (int i = 0; i < 11; i++)
      begin
         pair.full = random_bits(32);
         shift_case(op_ashc, 16'(edge_counts[i]), pair);
      end
      // positive long shifted right until nothing is left
      pair.full = 32'h1234_5678;
      shift_case(op_ashc, 16'(-31), pair);
      close_test("ashc");

      open_test;
      ignored_start_case;
      close_test("busy");

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire
